//--- core_pkg.sv
package core_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths and reset vector
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 4;   // RV32E, 16 registers.

	localparam logic [XLEN-1:0] RESET_PC = 32'h3000_0000;

	// Branch conditions in funct3.
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcodes and ALU operations
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State machines
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		fetch_idle,   // Only right after reset.
		fetch_addr,
		fetch_data,
		fetch_wait
	} fetch_state_t;

	typedef enum logic {
		mem_idle,
		mem_access
	} mem_state_t;

endpackage

//--- core_ifu.sv
`timescale 1ns/1ps

module core_ifu import core_pkg::*; (
	input  logic            clock,
	input  logic            rst,
	output logic            imem_arvalid,
	output logic [XLEN-1:0] imem_araddr,
	input  logic            imem_arready,
	input  logic            imem_rvalid,
	input  logic [XLEN-1:0] imem_rdata,
	input  logic            wb_valid,
	input  logic [XLEN-1:0] next_pc,
	output logic            inst_valid,
	output logic [XLEN-1:0] inst,
	output logic [XLEN-1:0] pc
);

	fetch_state_t state;

	assign imem_arvalid = (state == fetch_addr);
	assign imem_araddr  = pc;

	always_ff @(posedge clock) begin
		if (rst) begin
			state      <= fetch_idle;
			pc         <= RESET_PC;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			case (state)
				fetch_idle: state <= fetch_addr;
				fetch_addr: begin
					if (imem_arready) state <= fetch_data;   // Address accepted.
				end
				fetch_data: begin
					if (imem_rvalid) begin
						inst_valid <= 1'b1;
						state      <= fetch_wait;
					end
				end
				default: begin
					if (wb_valid) begin   // Previous instruction retired.
						pc    <= next_pc;
						state <= fetch_addr;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == fetch_data && imem_rvalid) inst <= imem_rdata;
	end

	araddr_stable: assert property (@(posedge clock) disable iff (rst)
		imem_arvalid && !imem_arready |=> $stable(imem_araddr));

endmodule

//--- core_idu.sv
`timescale 1ns/1ps

module core_idu import core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  inst_valid,
	input  logic [XLEN-1:0]       inst,
	input  logic [XLEN-1:0]       pc,
	output logic                  dec_valid,
	output logic [REG_ADDR_W-1:0] rs1,
	output logic [REG_ADDR_W-1:0] rs2,
	output logic [REG_ADDR_W-1:0] rd,
	output logic [XLEN-1:0]       imm,
	output logic [XLEN-1:0]       dec_pc,
	output opcode_t               opcode,
	output alu_op_t               alu_op,
	output logic [2:0]            funct3,
	output logic                  reg_wen
);

	opcode_t   op_in;
	logic [XLEN-1:0] imm_next;
	alu_op_t   alu_next;
	logic      wen_next;

	assign op_in = opcode_t'(inst[6:0]);

	always_comb begin
		imm_next = {{20{inst[31]}}, inst[31:20]};   // I format.
		alu_next = alu_add;
		wen_next = 1'b0;
		case (op_in)
			op_store:  imm_next = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			op_branch: imm_next = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
				inst[11:8], 1'b0};
			op_lui, op_auipc: imm_next = {inst[31:12], 12'b0};
			op_jal: imm_next = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
				inst[30:21], 1'b0};
			default: ;
		endcase

		if (op_in == op_reg || op_in == op_imm) begin
			case (inst[14:12])
				3'b000:  alu_next = (op_in == op_reg && inst[30]) ? alu_sub : alu_add;
				3'b001:  alu_next = alu_sll;
				3'b010:  alu_next = alu_slt;
				3'b011:  alu_next = alu_sltu;
				3'b100:  alu_next = alu_xor;
				3'b101:  alu_next = inst[30] ? alu_sra : alu_srl;
				3'b110:  alu_next = alu_or;
				default: alu_next = alu_and;
			endcase
		end

		case (op_in)
			op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg: wen_next = 1'b1;
			default: wen_next = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) dec_valid <= 1'b0;
		else     dec_valid <= inst_valid;
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			rs1     <= inst[15 +: REG_ADDR_W];
			rs2     <= inst[20 +: REG_ADDR_W];
			rd      <= inst[7 +: REG_ADDR_W];
			imm     <= imm_next;
			dec_pc  <= pc;
			opcode  <= op_in;
			alu_op  <= alu_next;
			funct3  <= inst[14:12];
			reg_wen <= wen_next && (inst[11:7] != 5'd0);   // x0 is never written.
		end
	end

	dec_single: assert property (@(posedge clock) disable iff (rst)
		dec_valid |=> !dec_valid);

endmodule

//--- core_regfile.sv
`timescale 1ns/1ps

module core_regfile import core_pkg::*; (
	input  logic                  clock,
	input  logic [REG_ADDR_W-1:0] raddr1,
	input  logic [REG_ADDR_W-1:0] raddr2,
	output logic [XLEN-1:0]       rdata1,
	output logic [XLEN-1:0]       rdata2,
	input  logic                  wen,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic [XLEN-1:0]       wdata
);

	logic [XLEN-1:0] regs [0:(1 << REG_ADDR_W) - 1];

	// Register zero is hardwired.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	always_ff @(posedge clock) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

//--- core_exu.sv
`timescale 1ns/1ps

module core_exu import core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  dec_valid,
	input  opcode_t               opcode,
	input  alu_op_t               alu_op,
	input  logic [2:0]            funct3,
	input  logic [XLEN-1:0]       imm,
	input  logic [XLEN-1:0]       dec_pc,
	input  logic [XLEN-1:0]       src1,
	input  logic [XLEN-1:0]       src2,
	input  logic                  reg_wen,
	input  logic [REG_ADDR_W-1:0] rd,
	output logic                  exe_valid,
	output logic [XLEN-1:0]       result,
	output logic [XLEN-1:0]       next_pc,
	output logic [XLEN-1:0]       mem_addr,
	output logic [XLEN-1:0]       store_data,
	output opcode_t               exe_opcode,
	output logic [REG_ADDR_W-1:0] exe_rd,
	output logic                  exe_wen,
	output logic [XLEN-1:0]       exe_pc
);

	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] res_next;
	logic [XLEN-1:0] npc_next;
	logic            taken;

	assign op_b = (opcode == op_reg) ? src2 : imm;

	always_comb begin
		case (alu_op)
			alu_sub:  alu_out = src1 - op_b;
			alu_sll:  alu_out = src1 << op_b[4:0];
			alu_slt:  alu_out = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(op_b)};
			alu_sltu: alu_out = {{(XLEN-1){1'b0}}, src1 < op_b};
			alu_xor:  alu_out = src1 ^ op_b;
			alu_srl:  alu_out = src1 >> op_b[4:0];
			alu_sra:  alu_out = $unsigned($signed(src1) >>> op_b[4:0]);
			alu_or:   alu_out = src1 | op_b;
			alu_and:  alu_out = src1 & op_b;
			default:  alu_out = src1 + op_b;
		endcase

		case (funct3)
			F3_BEQ:  taken = (src1 == src2);
			F3_BNE:  taken = (src1 != src2);
			F3_BLT:  taken = ($signed(src1) < $signed(src2));
			F3_BGE:  taken = ($signed(src1) >= $signed(src2));
			F3_BLTU: taken = (src1 < src2);
			F3_BGEU: taken = (src1 >= src2);
			default: taken = 1'b0;
		endcase

		res_next = alu_out;
		npc_next = dec_pc + 32'd4;
		case (opcode)
			op_lui:   res_next = imm;
			op_auipc: res_next = dec_pc + imm;
			op_jal: begin
				res_next = dec_pc + 32'd4;   // Link value.
				npc_next = dec_pc + imm;
			end
			op_jalr: begin
				res_next = dec_pc + 32'd4;
				npc_next = (src1 + imm) & ~32'd1;
			end
			op_branch: begin
				if (taken) npc_next = dec_pc + imm;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) exe_valid <= 1'b0;
		else     exe_valid <= dec_valid;
	end

	always_ff @(posedge clock) begin
		if (dec_valid) begin
			result     <= res_next;
			next_pc    <= npc_next;
			mem_addr   <= src1 + imm;
			store_data <= src2;
			exe_opcode <= opcode;
			exe_rd     <= rd;
			exe_wen    <= reg_wen;
			exe_pc     <= dec_pc;
		end
	end

endmodule

//--- core_lsu.sv
`timescale 1ns/1ps

module core_lsu import core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  exe_valid,
	input  opcode_t               exe_opcode,
	input  logic [XLEN-1:0]       result,
	input  logic [XLEN-1:0]       mem_addr,
	input  logic [XLEN-1:0]       store_data,
	input  logic [REG_ADDR_W-1:0] exe_rd,
	input  logic                  exe_wen,
	input  logic [XLEN-1:0]       exe_pc,
	output logic                  dmem_valid,
	output logic                  dmem_write,
	output logic [XLEN-1:0]       dmem_addr,
	output logic [XLEN-1:0]       dmem_wdata,
	input  logic                  dmem_ready,
	input  logic [XLEN-1:0]       dmem_rdata,
	output logic                  wb_valid,
	output logic [REG_ADDR_W-1:0] wb_rd,
	output logic [XLEN-1:0]       wb_data,
	output logic                  wb_wen,
	output logic [XLEN-1:0]       wb_pc
);

	mem_state_t state;
	logic       is_mem;
	logic       done;

	assign is_mem     = (exe_opcode == op_load) || (exe_opcode == op_store);
	assign dmem_valid = (state == mem_access);

	// Retire now for ALU ops, or when the bus answers.
	assign done = (exe_valid && !is_mem) || (dmem_valid && dmem_ready);

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= mem_idle;
			wb_valid <= 1'b0;
			wb_wen   <= 1'b0;
		end else begin
			wb_valid <= done;
			wb_wen   <= done && exe_wen;   // Only high alongside wb_valid.
			if (state == mem_idle && exe_valid && is_mem) state <= mem_access;
			else if (dmem_valid && dmem_ready)            state <= mem_idle;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request and write-back payload
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (exe_valid && is_mem) begin
			dmem_write <= (exe_opcode == op_store);
			dmem_addr  <= mem_addr;
			dmem_wdata <= store_data;
		end
		if (done) begin
			wb_rd   <= exe_rd;
			wb_pc   <= exe_pc;
			wb_data <= (dmem_valid && !dmem_write) ? dmem_rdata : result;
		end
	end

	dmem_aligned: assert property (@(posedge clock) disable iff (rst)
		dmem_valid |-> dmem_addr[1:0] == 2'b00);

endmodule

//--- core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst,
	output logic                  imem_arvalid,
	output logic [XLEN-1:0]       imem_araddr,
	input  logic                  imem_arready,
	input  logic                  imem_rvalid,
	input  logic [XLEN-1:0]       imem_rdata,
	output logic                  dmem_valid,
	output logic                  dmem_write,
	output logic [XLEN-1:0]       dmem_addr,
	output logic [XLEN-1:0]       dmem_wdata,
	input  logic                  dmem_ready,
	input  logic [XLEN-1:0]       dmem_rdata,
	output logic                  commit_valid,
	output logic [XLEN-1:0]       commit_pc,
	output logic [REG_ADDR_W-1:0] commit_rd,
	output logic [XLEN-1:0]       commit_data,
	output logic                  commit_wen
);

	logic                  inst_valid, dec_valid, exe_valid, wb_valid;
	logic [XLEN-1:0]       inst, pc, imm, dec_pc, src1, src2;
	logic [REG_ADDR_W-1:0] rs1, rs2, rd, exe_rd, wb_rd;
	opcode_t               opcode, exe_opcode;
	alu_op_t               alu_op;
	logic [2:0]            funct3;
	logic                  reg_wen, exe_wen, wb_wen;
	logic [XLEN-1:0]       result, next_pc, mem_addr, store_data, exe_pc, wb_data, wb_pc;

	assign commit_valid = wb_valid;   // Commit port mirrors write-back.
	assign commit_pc    = wb_pc;
	assign commit_rd    = wb_rd;
	assign commit_data  = wb_data;
	assign commit_wen   = wb_wen;

	core_ifu ifu_i (.clock, .rst, .imem_arvalid, .imem_araddr, .imem_arready,
		.imem_rvalid, .imem_rdata, .wb_valid, .next_pc, .inst_valid, .inst, .pc);

	core_idu idu_i (.clock, .rst, .inst_valid, .inst, .pc, .dec_valid, .rs1, .rs2,
		.rd, .imm, .dec_pc, .opcode, .alu_op, .funct3, .reg_wen);

	core_regfile regfile_i (.clock, .raddr1(rs1), .raddr2(rs2), .rdata1(src1),
		.rdata2(src2), .wen(wb_wen), .waddr(wb_rd), .wdata(wb_data));

	core_exu exu_i (.clock, .rst, .dec_valid, .opcode, .alu_op, .funct3, .imm,
		.dec_pc, .src1, .src2, .reg_wen, .rd, .exe_valid, .result, .next_pc,
		.mem_addr, .store_data, .exe_opcode, .exe_rd, .exe_wen, .exe_pc);

	core_lsu lsu_i (.clock, .rst, .exe_valid, .exe_opcode, .result, .mem_addr,
		.store_data, .exe_rd, .exe_wen, .exe_pc, .dmem_valid, .dmem_write,
		.dmem_addr, .dmem_wdata, .dmem_ready, .dmem_rdata, .wb_valid, .wb_rd,
		.wb_data, .wb_wen, .wb_pc);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic rst
);

	initial clock = 1'b0;
	always #20 clock = ~clock;   // 40 ns period.

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
	end

endmodule

//--- tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

	localparam int NUM_COMMITS = 40;
	localparam int TIMEOUT     = NUM_COMMITS * 20;

	logic clock, rst;
	logic imem_arvalid, dmem_valid, dmem_write, commit_valid, commit_wen;
	logic [XLEN-1:0] imem_araddr, dmem_addr, dmem_wdata, commit_pc, commit_data;
	logic [REG_ADDR_W-1:0] commit_rd;
	logic            imem_arready = 1'b0;
	logic            imem_rvalid  = 1'b0;
	logic [XLEN-1:0] imem_rdata   = '0;
	logic            dmem_ready   = 1'b0;
	logic [XLEN-1:0] dmem_rdata   = '0;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:255];
	logic [31:0] ref_mem [0:255];
	logic [31:0] ref_regs [0:15];
	logic [31:0] ref_pc;
	int seed = 32'h7b0e_e88e;
	int errors = 0;
	int commits = 0;
	int cycles = 0;

	tb_clock_gen clk_i (.clock, .rst);

	core_top dut_i (.clock, .rst, .imem_arvalid, .imem_araddr, .imem_arready, .imem_rvalid,
		.imem_rdata, .dmem_valid, .dmem_write, .dmem_addr, .dmem_wdata, .dmem_ready,
		.dmem_rdata, .commit_valid, .commit_pc, .commit_rd, .commit_data, .commit_wen);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction encoders
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program and memory contents
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		for (int i = 0; i < 64; i++) imem[i] = 32'h0000_0013;   // NOP filler.
		for (int i = 0; i < 256; i++) begin
			dmem[i]    = (32'h3000_1000 + 4 * i) ^ 32'h5a5a_5a5a;
			ref_mem[i] = dmem[i];
		end
		for (int i = 0; i < 16; i++) ref_regs[i] = '0;
		ref_pc = RESET_PC;
		imem[0]  = enc_i(5, 0, 3'b000, 1, 7'b0010011);
		imem[1]  = enc_i(-3, 0, 3'b000, 2, 7'b0010011);
		imem[2]  = enc_r(7'h00, 2, 1, 3'b000, 3);          // add
		imem[3]  = enc_r(7'h20, 1, 2, 3'b000, 4);          // sub
		imem[4]  = enc_r(7'h00, 1, 2, 3'b010, 5);          // slt
		imem[5]  = enc_r(7'h00, 1, 2, 3'b011, 6);          // sltu
		imem[6]  = enc_i(4, 2, 3'b001, 7, 7'b0010011);     // slli
		imem[7]  = enc_i(32'h401, 2, 3'b101, 8, 7'b0010011);   // srai
		imem[8]  = enc_i(28, 2, 3'b101, 9, 7'b0010011);    // srli
		imem[9]  = enc_i(32'hff, 1, 3'b100, 10, 7'b0010011);
		imem[10] = enc_i(32'h70, 2, 3'b110, 11, 7'b0010011);
		imem[11] = enc_i(32'h3c, 2, 3'b111, 12, 7'b0010011);
		imem[12] = enc_r(7'h00, 1, 1, 3'b001, 13);         // sll
		imem[13] = enc_r(7'h20, 1, 2, 3'b101, 13);         // sra
		imem[14] = enc_i(7, 1, 3'b000, 0, 7'b0010011);     // Write to x0.
		imem[15] = enc_r(7'h00, 1, 0, 3'b000, 13);
		imem[16] = {20'h30001, 5'd14, 7'b0110111};         // lui
		imem[17] = {20'h00012, 5'd15, 7'b0010111};         // auipc
		imem[18] = enc_s(8, 1, 14);
		imem[19] = enc_s(12, 2, 14);
		imem[20] = enc_i(8, 14, 3'b010, 12, 7'b0000011);
		imem[21] = enc_i(12, 14, 3'b010, 13, 7'b0000011);
		imem[22] = enc_b(8, 1, 1, 3'b000);                 // Taken beq.
		imem[23] = enc_i(99, 0, 3'b000, 1, 7'b0010011);
		imem[24] = enc_b(8, 1, 1, 3'b001);                 // Untaken bne.
		imem[25] = enc_b(8, 1, 2, 3'b100);                 // Taken blt.
		imem[26] = enc_i(99, 0, 3'b000, 1, 7'b0010011);
		imem[27] = enc_b(8, 1, 2, 3'b101);                 // Untaken bge.
		imem[28] = enc_b(8, 2, 1, 3'b110);                 // Taken bltu.
		imem[29] = enc_i(99, 0, 3'b000, 1, 7'b0010011);
		imem[30] = enc_b(8, 2, 1, 3'b111);                 // Untaken bgeu.
		imem[31] = enc_j(8, 1);
		imem[32] = enc_i(99, 0, 3'b000, 1, 7'b0010011);
		imem[33] = {20'h00000, 5'd6, 7'b0010111};
		imem[34] = enc_i(13, 6, 3'b000, 3, 7'b1100111);    // jalr with an odd offset.
		imem[35] = enc_i(99, 0, 3'b000, 1, 7'b0010011);
		imem[36] = enc_r(7'h00, 2, 1, 3'b110, 4);
		imem[37] = enc_r(7'h00, 2, 1, 3'b011, 5);
		imem[38] = enc_j(0, 0);                            // Loop forever.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic       ibus_data_phase = 1'b0;
	logic [1:0] ibus_wait = 2'd0;
	logic [31:0] ibus_addr = '0;
	logic [1:0] dbus_wait = 2'd0;

	always @(posedge clock) begin
		imem_arready <= 1'b0;
		imem_rvalid  <= 1'b0;
		if (!ibus_data_phase && imem_arvalid && !rst) begin
			if (ibus_wait == 0) begin
				imem_arready    <= 1'b1;
				ibus_addr       <= imem_araddr;
				ibus_data_phase <= 1'b1;
				ibus_wait       <= 2'($random(seed));
			end else ibus_wait <= ibus_wait - 1;
		end else if (ibus_data_phase) begin
			if (ibus_wait == 0) begin
				imem_rvalid     <= 1'b1;
				imem_rdata      <= imem[6'((ibus_addr - RESET_PC) >> 2)];
				ibus_data_phase <= 1'b0;
				ibus_wait       <= 2'($random(seed));
			end else ibus_wait <= ibus_wait - 1;
		end
	end

	always @(posedge clock) begin
		dmem_ready <= 1'b0;
		if (dmem_valid && !dmem_ready && !rst) begin
			if (dbus_wait == 0) begin
				dmem_ready <= 1'b1;
				if (dmem_write) dmem[dmem_addr[9:2]] <= dmem_wdata;
				else            dmem_rdata <= dmem[dmem_addr[9:2]];
				dbus_wait <= 2'($random(seed));
			end else dbus_wait <= dbus_wait - 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Steps the architectural state by one instruction.
	function automatic void ref_step(output logic [31:0] e_pc, output logic [3:0] e_rd,
			output logic [31:0] e_data, output logic e_wen);
		logic [31:0] inst, a, b, res, npc, imm_i, imm_s, imm_b, imm_j;
		logic        wr;
		logic        take;
		inst  = imem[6'((ref_pc - RESET_PC) >> 2)];
		a     = ref_regs[inst[18:15]];
		b     = ref_regs[inst[23:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		npc   = ref_pc + 4;
		res   = '0;
		wr    = 1'b1;
		take  = 1'b0;
		case (inst[6:0])
			7'b0110111: res = {inst[31:12], 12'b0};
			7'b0010111: res = ref_pc + {inst[31:12], 12'b0};
			7'b1101111: begin
				res = ref_pc + 4;
				npc = ref_pc + imm_j;
			end
			7'b1100111: begin
				res = ref_pc + 4;
				npc = (a + imm_i) & 32'hffff_fffe;
			end
			7'b1100011: begin
				wr = 1'b0;
				case (inst[14:12])
					3'b000: take = a == b;
					3'b001: take = a != b;
					3'b100: take = $signed(a) < $signed(b);
					3'b101: take = $signed(a) >= $signed(b);
					3'b110: take = a < b;
					3'b111: take = a >= b;
					default: take = 1'b0;
				endcase
				if (take) npc = ref_pc + imm_b;
			end
			7'b0000011: res = ref_mem[8'((a + imm_i) >> 2)];
			7'b0100011: begin
				wr = 1'b0;
				ref_mem[8'((a + imm_s) >> 2)] = b;
			end
			default: begin   // OP and OP-IMM.
				if (inst[6:0] == 7'b0010011) b = imm_i;
				case (inst[14:12])
					3'b000: res = (inst[5] && inst[30]) ? a - b : a + b;
					3'b001: res = a << b[4:0];
					3'b010: res = {31'b0, $signed(a) < $signed(b)};
					3'b011: res = {31'b0, a < b};
					3'b100: res = a ^ b;
					3'b101: res = inst[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
					3'b110: res = a | b;
					default: res = a & b;
				endcase
			end
		endcase
		e_pc   = ref_pc;
		e_rd   = inst[10:7];
		e_data = res;
		e_wen  = wr && inst[11:7] != 0;
		if (e_wen) ref_regs[e_rd] = res;
		ref_pc = npc;
	endfunction

	task automatic finish_run();
		$display("Commits: %0d, errors: %0d", commits, errors);
		if (errors == 0) $display("SIMULATION PASSED");
		else $display("SIMULATION FAILED");
		$finish;
	endtask

	always @(posedge clock) begin : compare
		logic [31:0] e_pc, e_data;
		logic [3:0]  e_rd;
		logic        e_wen;
		if (rst && (imem_arvalid || dmem_valid)) begin
			$display("Bus request seen while reset is high at %0t", $time);
			errors++;
		end
		if (!rst) cycles++;
		if (!rst && commit_valid) begin
			if (commits == 0 && commit_pc != RESET_PC) begin
				$display("FAILED %0t: first commit pc %h is not the reset pc", $time, commit_pc);
				errors++;
			end
			ref_step(e_pc, e_rd, e_data, e_wen);
			if (commit_pc != e_pc) begin
				$display("FAILED %0t: pc got %h expected %h", $time, commit_pc, e_pc);
				errors++;
			end
			if (commit_wen != e_wen) begin
				$display("FAILED %0t: pc %h wen got %b expected %b", $time, e_pc,
					commit_wen, e_wen);
				errors++;
			end
			if (e_wen && (commit_rd != e_rd || commit_data != e_data)) begin
				$display("FAILED %0t: pc %h x%0d=%h expected x%0d=%h", $time, e_pc,
					commit_rd, commit_data, e_rd, e_data);
				errors++;
			end
			commits++;
		end
		if (commits == NUM_COMMITS) begin
			finish_run();
		end else if (cycles >= TIMEOUT) begin
			$display("timeout: core stopped committing");
			errors++;
			finish_run();
		end
	end

endmodule

//--- flist.f
core_pkg.sv
core_ifu.sv
core_idu.sv
core_regfile.sv
core_exu.sv
core_lsu.sv
core_top.sv
tb_clock_gen.sv
tb_core.sv

//--- Makefile
.PHONY: lint sim clean

LOG = sim.log

lint:
	verilator --lint-only --timing -Wno-fatal --top-module tb_core -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f flist.f -o tb_core
	./obj_dir/tb_core | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
